/* hw/cachePkg.sv */
`default_nettype none

package cachePkg;

  ////////////////////
  // geometry
  ////////////////////
  localparam int addrW         = 16;                   // cpu byte address
  localparam int dataW         = 16;                   // one cpu word
  localparam int tagW          = 6;                    // addr 15:10
  localparam int setW          = 6;                    // addr 9:4
  localparam int offW          = 3;                    // addr 3:1, word in block
  localparam int numSets       = 64;
  localparam int wordsPerBlock = 8;
  localparam int metaW         = 8;                    // lru + valid + tag
  localparam int blkW          = addrW - offW - 1;     // block number seen by memory

  localparam logic [offW-1:0] lastWord = offW'(wordsPerBlock - 1); // final refill beat

  ////////////////////
  // controller states
  ////////////////////
  localparam int stateW = 2;
  localparam logic [stateW-1:0] stIdle  = 2'd0;        // lookup, read hits finish here
  localparam logic [stateW-1:0] stWrite = 2'd1;        // write-through to memory
  localparam logic [stateW-1:0] stReq   = 2'd2;        // refill read request out
  localparam logic [stateW-1:0] stWait  = 2'd3;        // waiting on refill word

  ////////////////////
  // metadata byte
  ////////////////////
  typedef struct packed {
    logic            lru;                              // bit 7, set = most recently used
    logic            valid;                            // bit 6
    logic [tagW-1:0] tag;                              // bits 5:0
  } metaT;

  // cache side view of an address
  typedef struct packed {
    logic [tagW-1:0] tag;
    logic [setW-1:0] set;
    logic [offW-1:0] word;
    logic            byteSel;                          // ignored, no byte writes
  } cacheAddrT;

  // memory side view, block number plus word
  typedef struct packed {
    logic [blkW-1:0] block;
    logic [offW-1:0] word;
    logic            byteSel;
  } memAddrT;

  typedef union packed {
    cacheAddrT cache;                                  // used by the lookup
    memAddrT   mem;                                    // used to walk a refill
  } addrU;

endpackage

`default_nettype wire

/* hw/fillIf.sv */
`default_nettype none

interface fillIf;
  import cachePkg::*;

  logic             access;                            // cpu request present
  logic             cpuWe;                             // request is a write
  addrU             fillAddr;                          // refill word address
  logic [dataW-1:0] fillData;                          // refill word from memory
  logic             dataWe;                            // write one refill word
  logic             metaWe;                            // install tag after last word
  logic             hitWrite;                          // commit cpu write on hit
  logic             hit;                               // access found in a way

  modport lookup (
    input  access, cpuWe, fillAddr, fillData,
    input  dataWe, metaWe, hitWrite,
    output hit
  );

  modport ctrl (
    output access, cpuWe, fillAddr, fillData,
    output dataWe, metaWe, hitWrite,
    input  hit
  );

endinterface

`default_nettype wire

/* hw/dataArray.sv */
`default_nettype none

module dataArray (
  input  logic                       clk,
  input  logic                       we,
  input  logic [cachePkg::setW-1:0]  set,
  input  logic [cachePkg::offW-1:0]  word,
  input  logic [cachePkg::dataW-1:0] wdata,
  output logic [cachePkg::dataW-1:0] rdata
);
  import cachePkg::*;

  ////////////////////
  // storage
  ////////////////////
  logic [dataW-1:0] mem [numSets][wordsPerBlock];      // one way, 64 blocks x 8 words

  // read is async so a hit returns in the same cycle
  assign rdata = mem[set][word];                       // set/word pick the word

  // single word write per clock
  always_ff @(posedge clk) begin
    if (we) begin                                      // refill beat or write hit
      mem[set][word] <= wdata;
    end
  end

endmodule

`default_nettype wire

/* hw/metaArray.sv */
`default_nettype none

module metaArray (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      we,
  input  logic [cachePkg::setW-1:0] set,
  input  cachePkg::metaT            wmeta,
  output cachePkg::metaT            rmeta
);
  import cachePkg::*;

  ////////////////////
  // storage
  ////////////////////
  logic [metaW-1:0] mem [numSets];                     // lru, valid, tag per set

  assign rmeta = metaT'(mem[set]);                     // async read for hit check

  // reset empties the cache, valid and lru go low
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < numSets; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[set] <= wmeta;                               // written now, no delay stage
    end
  end

endmodule

`default_nettype wire

/* hw/cacheD.sv */
`default_nettype none

module cacheD (
  input  logic                       clk,
  input  logic                       arstN,
  input  logic [cachePkg::addrW-1:0] cpuAddr,
  input  logic [cachePkg::dataW-1:0] cpuWdata,
  output logic [cachePkg::dataW-1:0] cpuRdata,
  fillIf.lookup                      fill
);
  import cachePkg::*;

  addrU             cpuA;                              // cpu address, cache view
  metaT             lMeta, rMeta;                      // current metadata of the set
  metaT             lMetaNew, rMetaNew;                // metadata to write back
  logic             hitL, hitR;                        // per way tag match
  logic             victimR;                           // refill goes to right way
  logic             metaUpd;                           // lru touch on a hit
  logic             metaWr;                            // either way meta written
  logic             lDataWe, rDataWe;
  logic [offW-1:0]  wrWord;                            // word port of both ways
  logic [dataW-1:0] wrData;
  logic [dataW-1:0] lRdata, rRdata;

  assign cpuA = cpuAddr;

  ////////////////////
  // hit detection
  ////////////////////
  assign hitL     = lMeta.valid && (lMeta.tag == cpuA.cache.tag);
  assign hitR     = rMeta.valid && (rMeta.tag == cpuA.cache.tag);
  assign fill.hit = fill.access && (hitL || hitR);     // only meaningful with a request

  // left is victim when empty or not recently used
  assign victimR = lMeta.valid && lMeta.lru;

  ////////////////////
  // data steering
  ////////////////////
  assign wrWord  = fill.dataWe ? fill.fillAddr.mem.word : cpuA.cache.word; // refill walks words
  assign wrData  = fill.dataWe ? fill.fillData : cpuWdata;
  assign lDataWe = (fill.dataWe && !victimR) || (fill.hitWrite && hitL);
  assign rDataWe = (fill.dataWe && victimR) || (fill.hitWrite && hitR);

  assign cpuRdata = hitR ? rRdata : lRdata;            // left by default

  ////////////////////
  // metadata update
  ////////////////////
  // read hit touches lru right away, write hit when memory takes the write
  assign metaUpd = (fill.hit && !fill.cpuWe) || fill.hitWrite;
  assign metaWr  = metaUpd || fill.metaWe;

  always_comb begin
    lMetaNew = lMeta;                                  // keep tag and valid
    rMetaNew = rMeta;
    if (fill.metaWe) begin                             // install after last refill word
      if (victimR) begin
        rMetaNew = '{lru: 1'b1, valid: 1'b1, tag: cpuA.cache.tag};
        lMetaNew.lru = 1'b0;
      end else begin
        lMetaNew = '{lru: 1'b1, valid: 1'b1, tag: cpuA.cache.tag};
        rMetaNew.lru = 1'b0;
      end
    end else begin
      lMetaNew.lru = hitL;                             // hit way marked recent
      rMetaNew.lru = hitR;                             // other way cleared
    end
  end

  ////////////////////
  // way storage
  ////////////////////
  dataArray leftData (
    .clk   (clk),
    .we    (lDataWe),
    .set   (cpuA.cache.set),
    .word  (wrWord),
    .wdata (wrData),
    .rdata (lRdata)
  );

  dataArray rightData (
    .clk   (clk),
    .we    (rDataWe),
    .set   (cpuA.cache.set),
    .word  (wrWord),
    .wdata (wrData),
    .rdata (rRdata)
  );

  metaArray leftMeta (
    .clk   (clk),
    .arstN (arstN),
    .we    (metaWr),                                   // both ways always updated together
    .set   (cpuA.cache.set),
    .wmeta (lMetaNew),
    .rmeta (lMeta)
  );

  metaArray rightMeta (
    .clk   (clk),
    .arstN (arstN),
    .we    (metaWr),
    .set   (cpuA.cache.set),
    .wmeta (rMetaNew),
    .rmeta (rMeta)
  );

endmodule

`default_nettype wire

/* hw/missFsm.sv */
`default_nettype none

module missFsm (
  input  logic                       clk,
  input  logic                       arstN,
  input  logic                       cpuValid,
  input  logic                       cpuWe,
  input  logic [cachePkg::addrW-1:0] cpuAddr,
  input  logic [cachePkg::dataW-1:0] cpuWdata,
  output logic                       cpuReady,
  output logic                       memReqValid,
  input  logic                       memReqReady,
  output logic [cachePkg::addrW-1:0] memAddr,
  output logic                       memWe,
  output logic [cachePkg::dataW-1:0] memWdata,
  input  logic                       memRspValid,
  input  logic [cachePkg::dataW-1:0] memRdata,
  fillIf.ctrl                        fill
);
  import cachePkg::*;

  logic [stateW-1:0] state, stateNxt;
  logic [offW-1:0]   wordCnt;                          // refill word being fetched
  addrU              fillAddr;                         // memory view of refill address

  ////////////////////
  // refill address
  ////////////////////
  // same block as the cpu address, word field stepped by the counter
  always_comb begin
    fillAddr             = cpuAddr;
    fillAddr.mem.word    = wordCnt;
    fillAddr.mem.byteSel = 1'b0;
  end

  ////////////////////
  // next state
  ////////////////////
  always_comb begin
    stateNxt = state;
    case (state)
      stIdle: begin
        if (cpuValid && !fill.hit) begin
          stateNxt = stReq;                            // miss, allocate on read or write
        end else if (cpuValid && cpuWe) begin
          stateNxt = stWrite;                          // write hit goes through to memory
        end
      end
      stWrite: begin
        if (memReqReady) begin
          stateNxt = stIdle;
        end
      end
      stReq: begin
        if (memReqReady) begin
          stateNxt = stWait;
        end
      end
      default: begin                                   // stWait
        if (memRspValid) begin
          stateNxt = (wordCnt == lastWord) ? stIdle : stReq; // back to lookup after word 7
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= stIdle;
      wordCnt <= '0;
    end else begin
      state <= stateNxt;
      if (state == stIdle) begin
        wordCnt <= '0;                                 // each refill starts at word 0
      end else if (state == stWait && memRspValid) begin
        wordCnt <= wordCnt + 1'b1;
      end
    end
  end

  ////////////////////
  // datapath controls
  ////////////////////
  assign fill.access   = cpuValid && (state == stIdle || state == stWrite);
  assign fill.cpuWe    = cpuWe;
  assign fill.fillAddr = fillAddr;
  assign fill.fillData = memRdata;                     // response always accepted
  assign fill.dataWe   = (state == stWait) && memRspValid;
  assign fill.metaWe   = fill.dataWe && (wordCnt == lastWord); // tag goes in with the last word
  assign fill.hitWrite = (state == stWrite) && memReqReady;    // memory took the write

  ////////////////////
  // memory and cpu ports
  ////////////////////
  assign memReqValid = (state == stWrite) || (state == stReq);
  assign memWe       = (state == stWrite);
  assign memAddr     = (state == stWrite) ? cpuAddr : fillAddr; // stable while ready low
  assign memWdata    = cpuWdata;                       // cpu holds data until cpuReady

  // read hit finishes at once, a write when memory accepts it
  assign cpuReady = ((state == stIdle) && fill.hit && !cpuWe) || fill.hitWrite;

endmodule

`default_nettype wire

/* hw/cacheTop.sv */
`default_nettype none

module cacheTop (
  input  logic                       clk,
  input  logic                       arstN,
  // cpu side
  input  logic                       cpuValid,
  input  logic [cachePkg::addrW-1:0] cpuAddr,
  input  logic                       cpuWe,
  input  logic [cachePkg::dataW-1:0] cpuWdata,
  output logic                       cpuReady,
  output logic [cachePkg::dataW-1:0] cpuRdata,
  // memory side
  output logic                       memReqValid,
  input  logic                       memReqReady,
  output logic [cachePkg::addrW-1:0] memAddr,
  output logic                       memWe,
  output logic [cachePkg::dataW-1:0] memWdata,
  input  logic                       memRspValid,
  input  logic [cachePkg::dataW-1:0] memRdata
);

  fillIf fill ();                                      // controller to datapath link

  cacheD lookup (
    .clk      (clk),
    .arstN    (arstN),
    .cpuAddr  (cpuAddr),
    .cpuWdata (cpuWdata),
    .cpuRdata (cpuRdata),                              // from the hitting way
    .fill     (fill.lookup)
  );

  missFsm ctrl (
    .clk         (clk),
    .arstN       (arstN),
    .cpuValid    (cpuValid),
    .cpuWe       (cpuWe),
    .cpuAddr     (cpuAddr),
    .cpuWdata    (cpuWdata),
    .cpuReady    (cpuReady),
    .memReqValid (memReqValid),
    .memReqReady (memReqReady),
    .memAddr     (memAddr),
    .memWe       (memWe),
    .memWdata    (memWdata),
    .memRspValid (memRspValid),
    .memRdata    (memRdata),
    .fill        (fill.ctrl)
  );

endmodule

`default_nettype wire

/* verification/cacheTb.sv */
`default_nettype none

module cacheTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int     numRand      = 400;               // random accesses
  localparam int     numDirected  = 6;                 // lru sequence
  localparam int     accessCycles = 8 * 9 + 8;         // worst case of refill beats plus write-through
  localparam longint timeoutNs    = longint'(numRand + numDirected) * accessCycles * 40 + 2000;

  logic        clk = 1'b0;
  logic        arstN;
  logic        cpuValid, cpuWe, cpuReady;
  logic [15:0] cpuAddr, cpuWdata, cpuRdata;
  logic        memReqValid, memReqReady, memWe, memRspValid;
  logic [15:0] memAddr, memWdata, memRdata;

  logic [15:0] memImg [32768];                         // word addressed backing memory
  logic [15:0] expImg [32768];                         // what cpu reads must return
  logic [5:0]  mTag   [2][64];                         // shadow cache with way 0 on the left
  logic        mValid [2][64];
  logic        mLru   [2][64];
  logic [15:0] logAddr [$];                            // memory requests of current access
  logic [15:0] logData [$];
  logic        logWe   [$];
  int          errCount  = 0;
  int          missCount = 0;

  cacheTop DUT (
    .clk(clk), .arstN(arstN),
    .cpuValid(cpuValid), .cpuAddr(cpuAddr), .cpuWe(cpuWe), .cpuWdata(cpuWdata),
    .cpuReady(cpuReady), .cpuRdata(cpuRdata),
    .memReqValid(memReqValid), .memReqReady(memReqReady), .memAddr(memAddr),
    .memWe(memWe), .memWdata(memWdata), .memRspValid(memRspValid), .memRdata(memRdata)
  );

  always #20 clk = ~clk;                               // 40 ns period

  function automatic void reportError(input string msg);
    $display("%s", msg);
    errCount++;
  endfunction

  ////////////////////
  // reference model
  ////////////////////
  // returns 1 when the access misses, then leaves the model as after the hit
  function automatic logic modelAccess(input logic [15:0] addr);
    logic [5:0] tag;
    logic [5:0] set;
    int         way;
    tag = addr[15:10];
    set = addr[9:4];
    way = -1;
    for (int w = 0; w < 2; w++) begin
      if (mValid[w][set] && mTag[w][set] == tag) begin
        way = w;
      end
    end
    modelAccess = (way < 0);
    if (way < 0) begin
      way = (mValid[0][set] && mLru[0][set]) ? 1 : 0;  // left unless valid and recent
      mTag[way][set]   = tag;
      mValid[way][set] = 1'b1;
    end
    mLru[way][set]     = 1'b1;
    mLru[1 - way][set] = 1'b0;
  endfunction

  // eight reads of words 0..7 on a miss, then one write-through for a write
  function automatic void checkMemLog(input logic [15:0] addr, input logic we,
                                      input logic [15:0] wdata, input logic miss);
    int nRd;
    nRd = miss ? 8 : 0;
    if (logAddr.size() != nRd + int'(we)) begin
      reportError($sformatf("access to %h made %0d memory requests instead of %0d",
                            addr, logAddr.size(), nRd + int'(we)));
      return;
    end
    for (int i = 0; i < nRd; i++) begin
      if (logWe[i]) begin
        reportError($sformatf("refill word %0d was sent as a memory write", i));
      end
      if (logAddr[i] !== {addr[15:4], 3'(i), 1'b0}) begin
        reportError($sformatf("[FAIL] memAddr refill word %0d: got %h expected %h",
                              i, logAddr[i], {addr[15:4], 3'(i), 1'b0}));
      end
    end
    if (we) begin
      if (logWe[nRd] !== 1'b1) begin
        reportError($sformatf("[FAIL] memWe write-through: got %h expected 1", logWe[nRd]));
      end
      if (logAddr[nRd] !== addr) begin
        reportError($sformatf("[FAIL] memAddr write-through: got %h expected %h",
                              logAddr[nRd], addr));
      end
      if (logData[nRd] !== wdata) begin
        reportError($sformatf("[FAIL] memWdata: got %h expected %h", logData[nRd], wdata));
      end
    end
  endfunction

  // request must stay put while memory holds off
  function automatic void holdCheck(input logic [15:0] addr, input logic we,
                                    input logic [15:0] data);
    if (memReqValid !== 1'b1) begin
      reportError("memReqValid dropped before memory accepted the request");
    end
    if (memAddr !== addr || memWe !== we || memWdata !== data) begin
      reportError($sformatf("[FAIL] memAddr/memWe/memWdata moved: got %h/%h/%h expected %h/%h/%h",
                            memAddr, memWe, memWdata, addr, we, data));
    end
    if (!memReqReady && cpuReady !== 1'b0) begin
      reportError($sformatf("[FAIL] cpuReady under back-pressure: got %h expected 0", cpuReady));
    end
  endfunction

  ////////////////////
  // memory model
  ////////////////////
  initial begin : memModel
    logic [15:0] reqAddr;
    logic [15:0] reqData;
    logic        reqWe;
    int          delay;
    memReqReady = 1'b0;
    memRspValid = 1'b0;
    memRdata    = '0;
    wait (arstN === 1'b1);
    for (int i = 0; i < 32768; i++) begin
      memImg[i] = expImg[i];                           // same random image as the model
    end
    forever begin
      @(negedge clk);                                  // dut outputs settled here
      if (memReqValid === 1'b1) begin
        reqAddr = memAddr;
        reqWe   = memWe;
        reqData = memWdata;
        delay   = $urandom_range(3, 0);
        for (int d = 0; d <= delay; d++) begin
          @(posedge clk);
          #2;
          memReqReady = (d == delay);                  // low for delay cycles
          @(negedge clk);
          holdCheck(reqAddr, reqWe, reqData);
        end
        logAddr.push_back(reqAddr);
        logWe.push_back(reqWe);
        logData.push_back(reqData);
        @(posedge clk);                                // transfer edge
        #2;
        memReqReady = 1'b0;
        if (reqWe) begin
          memImg[reqAddr[15:1]] = reqData;
        end else begin
          delay = $urandom_range(3, 1);
          for (int d = 1; d < delay; d++) begin
            @(posedge clk);
            #2;
          end
          memRspValid = 1'b1;
          memRdata    = memImg[reqAddr[15:1]];
          @(posedge clk);
          #2;
          memRspValid = 1'b0;
        end
      end
    end
  end

  ////////////////////
  // cpu side
  ////////////////////
  // starts just after a rising edge, ends just after the completing edge
  task automatic cpuAccess(input logic we, input logic [15:0] addr, input logic [15:0] wdata,
                           output logic miss);
    logic [15:0] rdata;
    miss = modelAccess(addr);
    logAddr.delete();
    logData.delete();
    logWe.delete();
    cpuValid = 1'b1;
    cpuWe    = we;
    cpuAddr  = addr;
    cpuWdata = wdata;
    @(negedge clk);
    while (cpuReady !== 1'b1) begin
      @(negedge clk);
    end
    rdata = cpuRdata;
    @(posedge clk);
    #2;
    cpuValid = 1'b0;
    if (we) begin
      expImg[addr[15:1]] = wdata;
    end else if (rdata !== expImg[addr[15:1]]) begin
      reportError($sformatf("[FAIL] cpuRdata at %h: got %h expected %h",
                            addr, rdata, expImg[addr[15:1]]));
    end
    checkMemLog(addr, we, wdata, miss);
    missCount += int'(miss);
  endtask

  task automatic resetTest();
    repeat (10) begin
      @(negedge clk);
      if (cpuReady !== 1'b0 || memReqValid !== 1'b0) begin
        reportError($sformatf("[FAIL] cpuReady/memReqValid in reset: got %h/%h expected 0/0",
                              cpuReady, memReqValid));
      end
    end
    @(posedge clk);
    #2;
    arstN = 1'b1;
    repeat (2) begin                                   // idle right after release
      @(negedge clk);
      if (cpuReady !== 1'b0 || memReqValid !== 1'b0) begin
        reportError($sformatf("[FAIL] cpuReady/memReqValid after reset: got %h/%h expected 0/0",
                              cpuReady, memReqValid));
      end
    end
    @(posedge clk);
    #2;
  endtask

  // a, b fill set 9, a touched, c evicts b, a stays, b refills
  task automatic lruTest();
    logic [15:0] seq [6];
    logic [5:0]  expMiss;
    logic        miss;
    seq     = '{16'h4492, 16'h8896, 16'h4492, 16'hCC9A, 16'h4494, 16'h8890};
    expMiss = 6'b101011;                               // bit i for access i
    for (int i = 0; i < 6; i++) begin
      cpuAccess(1'b0, seq[i], 16'h0, miss);
      if (logAddr.size() != (expMiss[i] ? 8 : 0)) begin
        reportError($sformatf("lru access %0d to %h made %0d memory reads instead of %0d",
                              i, seq[i], logAddr.size(), expMiss[i] ? 8 : 0));
      end
    end
  endtask

  task automatic randomTest();
    logic [5:0]  setPool [3];
    logic [15:0] addr;
    logic        miss;
    setPool = '{6'd0, 6'd9, 6'd63};
    for (int n = 0; n < numRand; n++) begin
      addr = {6'($urandom_range(3, 0) * 21), setPool[$urandom_range(2, 0)], 4'($urandom)};
      cpuAccess($urandom_range(2, 0) == 0, addr, 16'($urandom), miss); // about 1 in 3 writes
      repeat ($urandom_range(1, 0)) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin : mainSeq
    int errBefore;
    arstN    = 1'b0;
    cpuValid = 1'b0;
    cpuWe    = 1'b0;
    cpuAddr  = '0;
    cpuWdata = '0;
    void'($urandom(15));
    for (int i = 0; i < 32768; i++) begin
      expImg[i] = 16'($urandom);
    end
    for (int s = 0; s < 64; s++) begin
      for (int w = 0; w < 2; w++) begin
        mTag[w][s]   = '0;
        mValid[w][s] = 1'b0;
        mLru[w][s]   = 1'b0;
      end
    end
    errBefore = errCount;
    resetTest();
    $display("reset test done, %0d errors", errCount - errBefore);
    errBefore = errCount;
    lruTest();
    $display("lru test done, %0d errors", errCount - errBefore);
    errBefore = errCount;
    randomTest();
    $display("random test done, %0d errors", errCount - errBefore);
    $display("3 tests, %0d accesses, %0d misses, %0d errors",
             numRand + numDirected, missCount, errCount);
    if (errCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(timeoutNs);
    $display("watchdog expired, the DUT stopped finishing accesses");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
hw/cachePkg.sv
hw/fillIf.sv
hw/dataArray.sv
hw/metaArray.sv
hw/cacheD.sv
hw/missFsm.sv
hw/cacheTop.sv
verification/cacheTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = cacheTb
FILELIST  = build.f
OBJDIR    = obj_dir
PASS      = test passed

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# run it and fail unless the pass line shows up
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJDIR)
